// ==== include/pio_rtn_params.svh ====
`ifndef PIO_RTN_PARAMS_SVH
`define PIO_RTN_PARAMS_SVH

// Return queue depth is 2**PRTQ_ADDR_WIDTH
`define PRTQ_ADDR_WIDTH 3

// Return data and CSR read data
`define PIO_DATA_WIDTH 128
`define CSR_DATA_WIDTH 64

// Transaction id fields
`define UCB_THR_WIDTH 5
`define UCB_BUF_WIDTH 2

// AXI4-Lite register port
`define AXIL_ADDR_WIDTH 8
`define AXIL_DATA_WIDTH 32

// Register byte addresses
`define PIO_CSR_ORD_ADDR      8'h00
`define PIO_CSR_RDATA_LO_ADDR 8'h04
`define PIO_CSR_RDATA_HI_ADDR 8'h08
`define PIO_CSR_INT_ADDR      8'h0C

`endif

// ==== design/pio_rtn_pkg.sv ====
`default_nettype none

`include "pio_rtn_params.svh"

package pio_rtn_pkg;

   // Bit 1 marks a full 128-bit return, bit 0 picks the low half
   typedef enum logic [1:0] {
      SIZE_WORD_HI = 2'b00,
      SIZE_WORD_LO = 2'b01,
      SIZE_DWORD   = 2'b10
   } pio_size_e;

   typedef struct packed {
      logic [`UCB_THR_WIDTH-1:0] thr_id;
      logic [`UCB_BUF_WIDTH-1:0] buf_id;
   } ucb_id_t;

   // One return queue entry
   typedef struct packed {
      logic [`PIO_DATA_WIDTH-1:0] data;
      ucb_id_t                    id;
      pio_size_e                  size;
      logic                       ue;
   } prtq_entry_t;

   // CSR read ack from the request queue
   typedef struct packed {
      logic    vld;
      ucb_id_t id;
      logic    stall_rd16;
      ucb_id_t rd16_id;
   } prqq_ack_t;

   typedef struct packed {
      logic    vld;
      ucb_id_t id;
   } mout_nack_t;

   // Return toward the bus side
   typedef struct packed {
      logic                       ack_vld;
      logic                       nack_vld;
      ucb_id_t                    id;
      logic [`PIO_DATA_WIDTH-1:0] data;
   } ucb_rtn_t;

endpackage

`default_nettype wire

// ==== design/prtq_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pio_rtn_params.svh"

module prtq_ram (
   input  wire logic                        clk,
   input  wire logic                        wr_en_n,
   input  wire logic [`PRTQ_ADDR_WIDTH-1:0] waddr,
   input  wire pio_rtn_pkg::prtq_entry_t    wentry,
   input  wire logic                        rd_en_n,
   input  wire logic [`PRTQ_ADDR_WIDTH-1:0] raddr,
   output pio_rtn_pkg::prtq_entry_t         rentry
);

   import pio_rtn_pkg::*;

   localparam int DEPTH = 1 << `PRTQ_ADDR_WIDTH;

   prtq_entry_t mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (!wr_en_n) begin
         mem[waddr] <= wentry;
      end
   end

   // Registered read port, holds its value while deselected
   always_ff @(posedge clk) begin
      if (!rd_en_n) begin
         rentry <= mem[raddr];
      end
   end

endmodule

`default_nettype wire

// ==== design/prtq_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pio_rtn_params.svh"

module prtq_ctl (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic                        ord_pio,
   input  wire logic [`CSR_DATA_WIDTH-1:0]  csr_rdata,
   input  wire logic                        min_push,
   input  wire pio_rtn_pkg::prtq_entry_t    min_entry,
   input  wire logic                        tag_byps,
   input  wire pio_rtn_pkg::prqq_ack_t      prqq,
   input  wire pio_rtn_pkg::mout_nack_t     mout,
   input  wire logic                        ucbp_ack_busy,
   input  wire pio_rtn_pkg::prtq_entry_t    rentry,
   output logic                             wr_en_n,
   output logic [`PRTQ_ADDR_WIDTH-1:0]      waddr,
   output pio_rtn_pkg::prtq_entry_t         wentry,
   output logic                             rd_en_n,
   output logic [`PRTQ_ADDR_WIDTH-1:0]      raddr,
   output pio_rtn_pkg::ucb_rtn_t            rtn,
   output logic                             mout_nack_pop,
   output logic                             decr_rd_pend_cnt,
   output logic                             rcv_rtrn16
);

   import pio_rtn_pkg::*;

   localparam int AW = `PRTQ_ADDR_WIDTH;

   typedef enum logic {
      POP_IDLE = 1'b0,
      POP_WAIT = 1'b1
   } pop_state_e;

   pop_state_e pop_sm;
   pop_state_e next_pop_sm;

   // Pointers carry an extra wrap bit
   logic [AW:0] wptr;
   logic [AW:0] rptr;
   logic [AW:0] next_wptr;
   logic [AW:0] next_rptr;
   logic [AW:0] wptr_d1;
   logic [AW:0] wptr_d2;

   logic                       prtq_drdy;
   logic                       prtq_ack;
   logic                       prtq_nack;
   logic                       prtq_pop;
   logic [`PIO_DATA_WIDTH-1:0] fmt_data;

   // Push side
   assign wr_en_n = ~min_push;
   assign waddr   = wptr[AW-1:0];
   assign wentry  = min_entry;

   always_comb begin
      if (min_push) begin
         next_wptr = wptr + 1'b1;
      end else begin
         next_wptr = wptr;
      end
   end

   // Read-16 return seen on a full push or on a matching nack pop
   assign rcv_rtrn16 = (min_push & (min_entry.size == SIZE_DWORD))
                     | (mout_nack_pop & prqq.stall_rd16 & (mout.id == prqq.rd16_id));

   // An entry reaches the RAM output two cycles after its push,
   // so readiness compares against the delayed write pointer
   assign prtq_drdy = (rptr != wptr_d2) & (tag_byps | ~ord_pio);

   assign prtq_ack  = (pop_sm == POP_IDLE) & prtq_drdy & ~rentry.ue;
   assign prtq_nack = (pop_sm == POP_IDLE) & prtq_drdy &  rentry.ue;

   // Size rule for queued data
   always_comb begin
      if (rentry.size == SIZE_DWORD) begin
         fmt_data = rentry.data;
      end else if (rentry.size == SIZE_WORD_LO) begin
         fmt_data = {2{rentry.data[`PIO_DATA_WIDTH/2-1:0]}};
      end else begin
         fmt_data = {2{rentry.data[`PIO_DATA_WIDTH-1:`PIO_DATA_WIDTH/2]}};
      end
   end

   // Return arbitration, CSR acks first, then queue, then mout nacks
   always_comb begin
      if (prqq.vld) begin
         rtn.ack_vld  = ~ucbp_ack_busy;
         rtn.nack_vld = 1'b0;
         rtn.id       = prqq.id;
         rtn.data     = {2{csr_rdata}};
      end else if (prtq_ack | prtq_nack) begin
         rtn.ack_vld  = prtq_ack  & ~ucbp_ack_busy;
         rtn.nack_vld = prtq_nack & ~ucbp_ack_busy;
         rtn.id       = rentry.id;
         rtn.data     = fmt_data;
      end else begin
         // Nacks carry no data
         rtn.ack_vld  = 1'b0;
         rtn.nack_vld = mout.vld & ~ucbp_ack_busy;
         rtn.id       = mout.id;
         rtn.data     = fmt_data;
      end
   end

   assign mout_nack_pop = ~prqq.vld
                        & ~(prtq_ack | prtq_nack)
                        & ~ucbp_ack_busy
                        & mout.vld;

   // CSR reads are not counted as pending
   assign decr_rd_pend_cnt = (rtn.ack_vld & ~prqq.vld) | rtn.nack_vld;

   // Pop side
   assign prtq_pop = ~ucbp_ack_busy & ~prqq.vld & (prtq_ack | prtq_nack);

   always_comb begin
      case (pop_sm)
         POP_IDLE: begin
            if (prtq_pop) begin
               next_pop_sm = POP_WAIT;
            end else begin
               next_pop_sm = POP_IDLE;
            end
         end
         POP_WAIT: next_pop_sm = POP_IDLE;
         default:  next_pop_sm = POP_IDLE;
      endcase
   end

   always_comb begin
      if (prtq_pop) begin
         next_rptr = rptr + 1'b1;
      end else begin
         next_rptr = rptr;
      end
   end

   // Read ahead at the next head, idle when nothing new to fetch
   assign raddr   = next_rptr[AW-1:0];
   assign rd_en_n = (next_rptr == wptr);

   always_ff @(posedge clk) begin
      if (reset) begin
         pop_sm  <= POP_IDLE;
         wptr    <= '0;
         rptr    <= '0;
         wptr_d1 <= '0;
         wptr_d2 <= '0;
      end else begin
         pop_sm  <= next_pop_sm;
         wptr    <= next_wptr;
         rptr    <= next_rptr;
         wptr_d1 <= wptr;
         wptr_d2 <= wptr_d1;
      end
   end

endmodule

`default_nettype wire

// ==== design/pio_csr_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pio_rtn_params.svh"

module pio_csr_axil (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic [`AXIL_ADDR_WIDTH-1:0]    awaddr,
   input  wire logic                           awvalid,
   output logic                                awready,
   input  wire logic [`AXIL_DATA_WIDTH-1:0]    wdata,
   input  wire logic [`AXIL_DATA_WIDTH/8-1:0]  wstrb,
   input  wire logic                           wvalid,
   output logic                                wready,
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  wire logic                           bready,
   input  wire logic [`AXIL_ADDR_WIDTH-1:0]    araddr,
   input  wire logic                           arvalid,
   output logic                                arready,
   output logic [`AXIL_DATA_WIDTH-1:0]         rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  wire logic                           rready,
   output logic                                ord_pio,
   output logic [`CSR_DATA_WIDTH-1:0]          csr_rdata,
   output logic                                int_vld
);

   localparam int DW = `AXIL_DATA_WIDTH;
   localparam int SW = `AXIL_DATA_WIDTH / 8;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic                         aw_full;
   logic                         w_full;
   logic [`AXIL_ADDR_WIDTH-1:0]  aw_addr_q;
   logic [DW-1:0]                w_data_q;
   logic [SW-1:0]                w_strb_q;
   logic                         aw_hs;
   logic                         w_hs;
   logic                         ar_hs;
   logic                         do_write;
   logic [`AXIL_ADDR_WIDTH-1:0]  wr_addr;
   logic [DW-1:0]                wr_data;
   logic [SW-1:0]                wr_strb;
   logic                         wr_hit;
   logic [DW-1:0]                rd_word;
   logic                         rd_hit;

   function automatic logic [DW-1:0] apply_strb(input logic [DW-1:0] cur,
                                                input logic [DW-1:0] data,
                                                input logic [SW-1:0] strb);
      logic [DW-1:0] res;
      res = cur;
      for (int i = 0; i < SW; i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = data[i*8 +: 8];
         end
      end
      return res;
   endfunction

   // One write outstanding, accept address and data in any order
   assign awready = ~aw_full & ~bvalid;
   assign wready  = ~w_full & ~bvalid;
   assign aw_hs   = awvalid & awready;
   assign w_hs    = wvalid & wready;

   // Forward a half taken this cycle so the response lands one cycle later
   assign wr_addr  = aw_full ? aw_addr_q : awaddr;
   assign wr_data  = w_full ? w_data_q : wdata;
   assign wr_strb  = w_full ? w_strb_q : wstrb;
   assign do_write = (aw_full | aw_hs) & (w_full | w_hs);

   assign wr_hit = (wr_addr == `PIO_CSR_ORD_ADDR)
                 | (wr_addr == `PIO_CSR_RDATA_LO_ADDR)
                 | (wr_addr == `PIO_CSR_RDATA_HI_ADDR)
                 | (wr_addr == `PIO_CSR_INT_ADDR);

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         aw_addr_q <= awaddr;
      end
      if (w_hs) begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
      if (do_write) begin
         bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         aw_full   <= 1'b0;
         w_full    <= 1'b0;
         bvalid    <= 1'b0;
         ord_pio   <= 1'b1;
         csr_rdata <= '0;
         int_vld   <= 1'b0;
      end else begin
         if (bvalid && bready) begin
            bvalid <= 1'b0;
         end
         if (do_write) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b1;
            case (wr_addr)
               `PIO_CSR_ORD_ADDR: begin
                  if (wr_strb[0]) ord_pio <= wr_data[0];
               end
               `PIO_CSR_RDATA_LO_ADDR: begin
                  csr_rdata[DW-1:0] <= apply_strb(csr_rdata[DW-1:0], wr_data, wr_strb);
               end
               `PIO_CSR_RDATA_HI_ADDR: begin
                  csr_rdata[`CSR_DATA_WIDTH-1:DW] <=
                     apply_strb(csr_rdata[`CSR_DATA_WIDTH-1:DW], wr_data, wr_strb);
               end
               `PIO_CSR_INT_ADDR: begin
                  if (wr_strb[0]) int_vld <= wr_data[0];
               end
               default: ;
            endcase
         end else begin
            if (aw_hs) aw_full <= 1'b1;
            if (w_hs) w_full <= 1'b1;
         end
      end
   end

   // Read side
   assign arready = ~rvalid;
   assign ar_hs   = arvalid & arready;

   always_comb begin
      rd_hit  = 1'b1;
      rd_word = '0;
      case (araddr)
         `PIO_CSR_ORD_ADDR:      rd_word[0] = ord_pio;
         `PIO_CSR_RDATA_LO_ADDR: rd_word = csr_rdata[DW-1:0];
         `PIO_CSR_RDATA_HI_ADDR: rd_word = csr_rdata[`CSR_DATA_WIDTH-1:DW];
         `PIO_CSR_INT_ADDR:      rd_word[0] = int_vld;
         default:                rd_hit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rdata <= rd_word;
         rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else if (ar_hs) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== design/pio_rtn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pio_rtn_params.svh"

module pio_rtn_top (
   input  wire logic                           clk,
   input  wire logic                           reset,
   input  wire logic                           min_push,
   input  wire pio_rtn_pkg::prtq_entry_t       min_entry,
   input  wire pio_rtn_pkg::prqq_ack_t         prqq,
   input  wire pio_rtn_pkg::mout_nack_t        mout,
   input  wire logic                           tag_byps,
   input  wire logic                           ucbp_ack_busy,
   input  wire logic [`AXIL_ADDR_WIDTH-1:0]    awaddr,
   input  wire logic                           awvalid,
   output wire logic                           awready,
   input  wire logic [`AXIL_DATA_WIDTH-1:0]    wdata,
   input  wire logic [`AXIL_DATA_WIDTH/8-1:0]  wstrb,
   input  wire logic                           wvalid,
   output wire logic                           wready,
   output wire logic [1:0]                     bresp,
   output wire logic                           bvalid,
   input  wire logic                           bready,
   input  wire logic [`AXIL_ADDR_WIDTH-1:0]    araddr,
   input  wire logic                           arvalid,
   output wire logic                           arready,
   output wire logic [`AXIL_DATA_WIDTH-1:0]    rdata,
   output wire logic [1:0]                     rresp,
   output wire logic                           rvalid,
   input  wire logic                           rready,
   output wire pio_rtn_pkg::ucb_rtn_t          rtn,
   output wire logic                           mout_nack_pop,
   output wire logic                           decr_rd_pend_cnt,
   output wire logic                           rcv_rtrn16,
   output wire logic                           int_vld
);

   import pio_rtn_pkg::*;

   logic                          ord_pio;
   logic [`CSR_DATA_WIDTH-1:0]    csr_rdata;
   logic                          wr_en_n;
   logic                          rd_en_n;
   logic [`PRTQ_ADDR_WIDTH-1:0]   waddr;
   logic [`PRTQ_ADDR_WIDTH-1:0]   raddr;
   prtq_entry_t                   wentry;
   prtq_entry_t                   rentry;

   pio_csr_axil u_csr (
      .clk, .reset,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .ord_pio, .csr_rdata, .int_vld
   );

   prtq_ctl u_ctl (
      .clk, .reset, .ord_pio, .csr_rdata,
      .min_push, .min_entry, .tag_byps, .prqq, .mout, .ucbp_ack_busy,
      .rentry, .wr_en_n, .waddr, .wentry, .rd_en_n, .raddr,
      .rtn, .mout_nack_pop, .decr_rd_pend_cnt, .rcv_rtrn16
   );

   // Return queue storage
   prtq_ram u_ram (
      .clk, .wr_en_n, .waddr, .wentry, .rd_en_n, .raddr, .rentry
   );

endmodule

`default_nettype wire

// ==== tests/tb_pio_rtn.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pio_rtn_params.svh"

module tb_pio_rtn;

   import pio_rtn_pkg::*;

   // One row of the stimulus table
   typedef struct {
      logic      push;
      pio_size_e size;
      logic      ue;
      ucb_id_t   id;
      logic      prqq;
      logic      mout;
      logic      rd16_match;
      logic      exp_nack;
   } step_t;

   localparam int TIMEOUT = 20;
   localparam logic [1:0] OKAY = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic                          clk = 1'b0;
   logic                          reset;
   logic                          min_push;
   prtq_entry_t                   min_entry;
   prqq_ack_t                     prqq;
   mout_nack_t                    mout;
   logic                          tag_byps;
   logic                          ucbp_ack_busy;
   logic [`AXIL_ADDR_WIDTH-1:0]   awaddr;
   logic                          awvalid;
   logic                          awready;
   logic [`AXIL_DATA_WIDTH-1:0]   wdata;
   logic [`AXIL_DATA_WIDTH/8-1:0] wstrb;
   logic                          wvalid;
   logic                          wready;
   logic [1:0]                    bresp;
   logic                          bvalid;
   logic                          bready;
   logic [`AXIL_ADDR_WIDTH-1:0]   araddr;
   logic                          arvalid;
   logic                          arready;
   logic [`AXIL_DATA_WIDTH-1:0]   rdata;
   logic [1:0]                    rresp;
   logic                          rvalid;
   logic                          rready;
   ucb_rtn_t                      rtn;
   logic                          mout_nack_pop;
   logic                          decr_rd_pend_cnt;
   logic                          rcv_rtrn16;
   logic                          int_vld;

   integer      seed = 32'h3182_cea0;
   int          errors;
   int          checks;
   int          decr_count;
   int          exp_decr;
   int          nsteps;
   logic [63:0] csr_value;
   step_t       steps [16];
   prtq_entry_t model [$];

   pio_rtn_top DUT (.*);

   always #50 clk = ~clk;

   // Overall limit on simulated time
   initial begin
      #2000000;
      $display("simulation time limit reached before the test sequence ended");
      $display("TESTBENCH FAILED");
      $finish;
   end

   always @(negedge clk) begin
      if (!reset && decr_rd_pend_cnt) begin
         decr_count++;
      end
   end

   task automatic check_value(input string name, input logic [127:0] actual,
                              input logic [127:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   function automatic string test_result(input int errors_before);
      return (errors == errors_before) ? "pass" : "fail";
   endfunction

   task automatic add_step(input logic push, input pio_size_e size, input logic ue,
                           input ucb_id_t id, input logic do_prqq, input logic do_mout,
                           input logic rd16_match, input logic exp_nack);
      steps[nsteps] = '{push, size, ue, id, do_prqq, do_mout, rd16_match, exp_nack};
      nsteps++;
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      bit aw_take;
      bit w_take;
      bit aw_done;
      bit w_done;
      int n;
      aw_done = 1'b0;
      w_done  = 1'b0;
      resp    = 2'bxx;
      n       = 0;
      @(posedge clk);
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= 4'hf;
      wvalid  <= 1'b1;
      while (!(aw_done && w_done) && n < TIMEOUT) begin
         @(negedge clk);
         aw_take = awvalid && awready;
         w_take  = wvalid && wready;
         @(posedge clk);
         if (aw_take) begin
            awvalid <= 1'b0;
            aw_done = 1'b1;
         end
         if (w_take) begin
            wvalid <= 1'b0;
            w_done = 1'b1;
         end
         n++;
      end
      if (!(aw_done && w_done)) begin
         report_failure("AXI write address or data was never accepted");
      end
      n = 0;
      @(negedge clk);
      while (!bvalid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (bvalid) begin
         resp = bresp;
      end else begin
         report_failure("AXI write response never arrived");
      end
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      bit ar_take;
      int n;
      ar_take = 1'b0;
      data    = 'x;
      resp    = 2'bxx;
      n       = 0;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      while (!ar_take && n < TIMEOUT) begin
         @(negedge clk);
         ar_take = arready;
         @(posedge clk);
         n++;
      end
      arvalid <= 1'b0;
      if (!ar_take) begin
         report_failure("AXI read address was never accepted");
      end
      n = 0;
      @(negedge clk);
      while (!rvalid && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (rvalid) begin
         data = rdata;
         resp = rresp;
      end else begin
         report_failure("AXI read data never arrived");
      end
   endtask

   function automatic prtq_entry_t make_entry(input pio_size_e size, input logic ue,
                                              input ucb_id_t id);
      prtq_entry_t e;
      e.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      e.id   = id;
      e.size = size;
      e.ue   = ue;
      return e;
   endfunction

   // Data seen on the bus side for a stored entry
   function automatic logic [127:0] expected_data(input prtq_entry_t e);
      case (e.size)
         SIZE_DWORD:   return e.data;
         SIZE_WORD_LO: return {e.data[63:0], e.data[63:0]};
         default:      return {e.data[127:64], e.data[127:64]};
      endcase
   endfunction

   // Leaves min_push high for the caller to drop
   task automatic push_entry(input prtq_entry_t e);
      @(posedge clk);
      min_push  <= 1'b1;
      min_entry <= e;
      model.push_back(e);
      @(negedge clk);
      check_value("rcv_rtrn16", rcv_rtrn16, e.size == SIZE_DWORD);
   endtask

   task automatic expect_return(input logic exp_nack);
      prtq_entry_t e;
      int n;
      n = 0;
      @(negedge clk);
      while (!(rtn.ack_vld || rtn.nack_vld) && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!(rtn.ack_vld || rtn.nack_vld)) begin
         report_failure("no queued return arrived within the timeout");
      end else if (model.size() == 0) begin
         report_failure("a queued return arrived with no entry pending");
      end else begin
         e = model.pop_front();
         exp_decr++;
         check_value("rtn.ack_vld", rtn.ack_vld, !exp_nack);
         check_value("rtn.nack_vld", rtn.nack_vld, exp_nack);
         check_value("rtn.id", rtn.id, e.id);
         check_value("decr_rd_pend_cnt", decr_rd_pend_cnt, 1'b1);
         if (!exp_nack) begin
            check_value("rtn.data", rtn.data, expected_data(e));
         end
      end
   endtask

   task automatic check_csr_ack(input ucb_id_t id);
      check_value("rtn.ack_vld", rtn.ack_vld, 1'b1);
      check_value("rtn.nack_vld", rtn.nack_vld, 1'b0);
      check_value("rtn.id", rtn.id, id);
      check_value("rtn.data", rtn.data, {csr_value, csr_value});
      check_value("decr_rd_pend_cnt", decr_rd_pend_cnt, 1'b0);
   endtask

   // Memory-out nack held off by back-pressure first
   task automatic mout_nack(input ucb_id_t id, input logic rd16_match);
      int n;
      n = 0;
      @(posedge clk);
      mout.vld         <= 1'b1;
      mout.id          <= id;
      prqq.stall_rd16  <= 1'b1;
      prqq.rd16_id     <= rd16_match ? id : id ^ 7'h01;
      ucbp_ack_busy    <= 1'b1;
      repeat (2) begin
         @(negedge clk);
         check_value("rtn.ack_vld", rtn.ack_vld, 1'b0);
         check_value("rtn.nack_vld", rtn.nack_vld, 1'b0);
         check_value("mout_nack_pop", mout_nack_pop, 1'b0);
      end
      @(posedge clk);
      ucbp_ack_busy <= 1'b0;
      @(negedge clk);
      while (!rtn.nack_vld && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!rtn.nack_vld) begin
         report_failure("memory-out nack never appeared after back-pressure was released");
      end else begin
         exp_decr++;
         check_value("rtn.ack_vld", rtn.ack_vld, 1'b0);
         check_value("rtn.id", rtn.id, id);
         check_value("mout_nack_pop", mout_nack_pop, 1'b1);
         check_value("decr_rd_pend_cnt", decr_rd_pend_cnt, 1'b1);
         check_value("rcv_rtrn16", rcv_rtrn16, rd16_match);
      end
      @(posedge clk);
      mout.vld        <= 1'b0;
      prqq.stall_rd16 <= 1'b0;
   endtask

   task automatic run_step(input step_t s);
      prtq_entry_t e;
      ucb_id_t     csr_id;
      csr_id = ~s.id;
      if (s.mout) begin
         mout_nack(s.id, s.rd16_match);
      end else if (s.push) begin
         e = make_entry(s.size, s.ue, s.id);
         // CSR ack held from before the push until the entry is ready
         if (s.prqq) begin
            @(posedge clk);
            prqq.vld <= 1'b1;
            prqq.id  <= csr_id;
         end
         push_entry(e);
         @(posedge clk);
         min_push <= 1'b0;
         if (s.prqq) begin
            repeat (3) begin
               @(negedge clk);
               check_csr_ack(csr_id);
               @(posedge clk);
            end
            prqq.vld <= 1'b0;
         end
         expect_return(s.exp_nack);
      end
   endtask

   initial begin
      int          t_err;
      int          n;
      bit          early;
      logic [31:0] rd;
      logic [1:0]  resp;
      prtq_entry_t e;

      reset         = 1'b1;
      min_push      = 1'b0;
      min_entry     = '0;
      prqq          = '0;
      mout          = '0;
      tag_byps      = 1'b0;
      ucbp_ack_busy = 1'b0;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wstrb         = '0;
      wvalid        = 1'b0;
      bready        = 1'b1;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b1;
      errors        = 0;
      checks        = 0;
      decr_count    = 0;
      exp_decr      = 0;
      nsteps        = 0;

      //        push size          ue  id     prqq mout match nack
      add_step(1'b1, SIZE_DWORD,   1'b0, 7'h05, 1'b0, 1'b0, 1'b0, 1'b0);
      add_step(1'b1, SIZE_WORD_LO, 1'b0, 7'h1a, 1'b0, 1'b0, 1'b0, 1'b0);
      add_step(1'b1, SIZE_WORD_HI, 1'b0, 7'h33, 1'b0, 1'b0, 1'b0, 1'b0);
      add_step(1'b1, SIZE_DWORD,   1'b1, 7'h47, 1'b0, 1'b0, 1'b0, 1'b1);
      add_step(1'b1, SIZE_WORD_LO, 1'b0, 7'h52, 1'b1, 1'b0, 1'b0, 1'b0);
      add_step(1'b0, SIZE_DWORD,   1'b0, 7'h61, 1'b0, 1'b1, 1'b0, 1'b1);
      add_step(1'b0, SIZE_DWORD,   1'b0, 7'h6e, 1'b0, 1'b1, 1'b1, 1'b1);
      add_step(1'b1, SIZE_WORD_HI, 1'b1, 7'h7c, 1'b1, 1'b0, 1'b0, 1'b1);

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // Register access over AXI4-Lite
      t_err = errors;
      csr_value = {$random(seed), $random(seed)};
      axil_read(`PIO_CSR_ORD_ADDR, rd, resp);
      check_value("ord_pio after reset", rd, 32'h1);
      axil_write(`PIO_CSR_ORD_ADDR, 32'h0, resp);
      check_value("bresp", resp, OKAY);
      axil_read(`PIO_CSR_ORD_ADDR, rd, resp);
      check_value("ord_pio", rd, 32'h0);
      axil_write(`PIO_CSR_RDATA_LO_ADDR, csr_value[31:0], resp);
      axil_write(`PIO_CSR_RDATA_HI_ADDR, csr_value[63:32], resp);
      axil_read(`PIO_CSR_RDATA_LO_ADDR, rd, resp);
      check_value("csr_rdata low", rd, csr_value[31:0]);
      axil_read(`PIO_CSR_RDATA_HI_ADDR, rd, resp);
      check_value("csr_rdata high", rd, csr_value[63:32]);
      check_value("rresp", resp, OKAY);
      axil_write(`PIO_CSR_INT_ADDR, 32'h1, resp);
      check_value("int_vld", int_vld, 1'b1);
      axil_read(`PIO_CSR_INT_ADDR, rd, resp);
      check_value("interrupt bit", rd, 32'h1);
      axil_write(`PIO_CSR_INT_ADDR, 32'h0, resp);
      check_value("int_vld", int_vld, 1'b0);
      axil_write(8'h10, 32'hffff_ffff, resp);
      check_value("bresp unmapped", resp, SLVERR);
      axil_read(8'h14, rd, resp);
      check_value("rresp unmapped", resp, SLVERR);
      $display("test registers: %s", test_result(t_err));

      for (int i = 0; i < nsteps; i++) begin
         t_err = errors;
         run_step(steps[i]);
         $display("test step %0d: %s", i, test_result(t_err));
      end

      // Back-to-back pushes held by back-pressure, then returned in order
      t_err = errors;
      @(posedge clk);
      ucbp_ack_busy <= 1'b1;
      for (int i = 0; i < 4; i++) begin
         push_entry(make_entry(pio_size_e'(i % 3), 1'b0, 7'(8'h10 + i)));
      end
      @(posedge clk);
      min_push      <= 1'b0;
      ucbp_ack_busy <= 1'b0;
      repeat (4) expect_return(1'b0);
      $display("test burst: %s", test_result(t_err));

      // Ordering holds the queue until tag bypass
      t_err = errors;
      axil_write(`PIO_CSR_ORD_ADDR, 32'h1, resp);
      e = make_entry(SIZE_WORD_HI, 1'b0, 7'h2d);
      push_entry(e);
      @(posedge clk);
      min_push <= 1'b0;
      early = 1'b0;
      n = 0;
      while (!early && n < TIMEOUT) begin
         @(negedge clk);
         early = rtn.ack_vld || rtn.nack_vld;
         n++;
      end
      if (early) begin
         report_failure("queued return appeared while ordering should hold it");
      end
      @(posedge clk);
      tag_byps <= 1'b1;
      expect_return(1'b0);
      @(posedge clk);
      tag_byps <= 1'b0;
      $display("test ordering: %s", test_result(t_err));

      check_value("decr_rd_pend_cnt pulses", decr_count, exp_decr);
      if (model.size() != 0) begin
         report_failure("entries left in the queue model at the end");
      end
      $display("%0d tests, %0d checks, %0d errors", nsteps + 3, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
design/pio_rtn_pkg.sv
design/prtq_ram.sv
design/prtq_ctl.sv
design/pio_csr_axil.sv
design/pio_rtn_top.sv
tests/tb_pio_rtn.sv

// ==== Bender.yml ====
package:
  name: pio_rtn

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/pio_rtn_pkg.sv
      - design/prtq_ram.sv
      - design/prtq_ctl.sv
      - design/pio_csr_axil.sv
      - design/pio_rtn_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_pio_rtn.sv
